// ==== sim.f ====
+incdir+hw
+incdir+dv
hw/whirlpool_pkg.sv
hw/whirlpool_sbox.sv
hw/whirlpool_round.sv
hw/whirlpool_wcipher.sv
hw/whirlpool_apb_regs.sv
hw/whirlpool_top.sv
dv/whirlpool_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module whirlpool_tb -f sim.f -o whirlpool_sim > build.log 2>&1 \
    && ./obj_dir/whirlpool_sim > sim.log 2>&1 \
    || echo "Build or simulation ended with an error status" >> sim.log

cat build.log sim.log
grep -q "Something failed" sim.log && exit 1 || grep -q "Everything OK" sim.log || exit 1
exit 0

// ==== dv/whirlpool_model.svh ====
`ifndef WHIRLPOOL_MODEL_SVH
`define WHIRLPOOL_MODEL_SVH

// Mini-boxes of the Whirlpool S-box with entry 0 in the top nibble
localparam logic [63:0] MINI_E = 64'h1b9cd6f3e874a250;
localparam logic [63:0] MINI_R = 64'h7cbde49f638a2510;
localparam logic [31:0] THETA_ROW = 32'h11418529; // First row of cir(1,1,4,1,8,5,2,9)

function automatic logic [3:0] nibble_of(input logic [63:0] tbl, input logic [3:0] x);
    return tbl[63 - 4 * x -: 4];
endfunction

function automatic logic [3:0] mini_e_inv(input logic [3:0] x);
    logic [3:0] inv;
    inv = '0;
    for (int v = 0; v < 16; v++) begin
        if (nibble_of(MINI_E, 4'(v)) == x) begin
            inv = 4'(v);
        end
    end
    return inv;
endfunction

function automatic logic [7:0] sbox_byte(input logic [7:0] x);
    logic [3:0] u;
    logic [3:0] l;
    logic [3:0] r;
    u = nibble_of(MINI_E, x[7:4]);
    l = mini_e_inv(x[3:0]);
    r = nibble_of(MINI_R, u ^ l);
    return {nibble_of(MINI_E, u ^ r), mini_e_inv(l ^ r)};
endfunction

// Product in GF(2^8) with the polynomial 0x11d
function automatic logic [7:0] gf_times(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] acc;
    p   = a;
    acc = '0;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            acc ^= p;
        end
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1d : 8'h00);
    end
    return acc;
endfunction

// Byte 8*row+col of a state sits at bits 511-8*(8*row+col) downwards
function automatic logic [511:0] model_round(input logic [511:0] s, input logic [511:0] k);
    logic [511:0] g;
    logic [511:0] t;
    logic [7:0]   acc;
    for (int r = 0; r < 8; r++) begin
        for (int c = 0; c < 8; c++) begin
            g[511 - 8 * (8 * ((r + c) % 8) + c) -: 8] =
                sbox_byte(s[511 - 8 * (8 * r + c) -: 8]); // Gamma then pi
        end
    end
    for (int r = 0; r < 8; r++) begin
        for (int c = 0; c < 8; c++) begin
            acc = '0;
            for (int m = 0; m < 8; m++) begin
                acc ^= gf_times(g[511 - 8 * (8 * r + m) -: 8],
                                {4'd0, THETA_ROW[31 - 4 * ((c - m + 8) % 8) -: 4]});
            end
            t[511 - 8 * (8 * r + c) -: 8] = acc;
        end
    end
    return t ^ k; // Sigma
endfunction

function automatic logic [511:0] w_encrypt(input logic [511:0] key, input logic [511:0] block);
    logic [511:0] k;
    logic [511:0] s;
    logic [511:0] rc;
    k = key;
    s = block ^ key;
    for (int r = 1; r <= `WP_ROUNDS; r++) begin
        rc = '0;
        for (int j = 0; j < 8; j++) begin
            rc[511 - 8 * j -: 8] = sbox_byte(8'(8 * (r - 1) + j));
        end
        k = model_round(k, rc);
        s = model_round(s, k);
    end
    return s;
endfunction

task automatic apb_write(input logic [`WP_APB_AW-1:0] addr, input logic [31:0] data,
                         output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr; // Sampled mid access phase
    check_value("pready", {31'd0, pready}, 32'd1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic apb_read(input logic [`WP_APB_AW-1:0] addr, output logic [31:0] data,
                        output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_value("pready", {31'd0, pready}, 32'd1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

`endif

// ==== dv/whirlpool_tb.sv ====
`include "whirlpool_settings.svh"

module whirlpool_tb;

    localparam int CLK_PERIOD = 10;
    localparam int ENC_COUNT  = 24;   // Timing pair, random run and busy test
    localparam int APB_COUNT  = 2000; // Transfers over all tests, rounded up
    localparam int TIMEOUT_CYCLES = 2 * (ENC_COUNT * 40 + APB_COUNT * 3);

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`WP_APB_AW-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [31:0]           saved_regs [49]; // Key, block, status and result words

    whirlpool_top u_whirlpool_top (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "whirlpool_model.svh"

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    function automatic logic [`WP_APB_AW-1:0] word_addr(input logic [`WP_APB_AW-1:0] base,
                                                        input int i);
        return base + 8'(4 * i);
    endfunction

    function automatic logic [`WP_APB_AW-1:0] reg_addr(input int n);
        if (n < 16) begin
            return word_addr(`WP_KEY_BASE, n);
        end else if (n < 32) begin
            return word_addr(`WP_BLOCK_BASE, n - 16);
        end else if (n == 32) begin
            return `WP_STATUS_ADDR;
        end
        return word_addr(`WP_RESULT_BASE, n - 33);
    endfunction

    function automatic logic [511:0] random_state();
        logic [511:0] s;
        for (int i = 0; i < 16; i++) begin
            s[511 - 32 * i -: 32] = $urandom;
        end
        return s;
    endfunction

    task automatic write_expect(input logic [`WP_APB_AW-1:0] addr, input logic [31:0] data,
                                input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        check_value($sformatf("pslverr on write to 0x%02h", addr), {31'd0, err}, {31'd0, exp_err});
    endtask

    task automatic read_check(input logic [`WP_APB_AW-1:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] d;
        logic        err;
        apb_read(addr, d, err);
        check_value($sformatf("pslverr on read of 0x%02h", addr), {31'd0, err}, 32'd0);
        check_value(name, d, exp);
    endtask

    task automatic load_key_block(input logic [511:0] k, input logic [511:0] b);
        for (int i = 0; i < 16; i++) begin
            write_expect(word_addr(`WP_KEY_BASE, i), k[511 - 32 * i -: 32], 1'b0);
            write_expect(word_addr(`WP_BLOCK_BASE, i), b[511 - 32 * i -: 32], 1'b0);
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st    = '0;
        while (st[1] !== 1'b1) begin
            apb_read(`WP_STATUS_ADDR, st, err);
            polls++;
            if (polls > 20) begin
                $display("The core did not report done within %0d status reads", polls);
                $display("Something failed");
                $fatal(1);
            end
        end
    endtask

    task automatic check_result(input logic [511:0] exp);
        for (int i = 0; i < 16; i++) begin
            read_check(word_addr(`WP_RESULT_BASE, i), exp[511 - 32 * i -: 32],
                       $sformatf("result[%0d]", i));
        end
    endtask

    task automatic capture_regs();
        logic [31:0] d;
        logic        err;
        for (int n = 0; n < 49; n++) begin
            apb_read(reg_addr(n), d, err);
            saved_regs[n] = d;
        end
    endtask

    task automatic check_regs_unchanged();
        for (int n = 0; n < 49; n++) begin
            read_check(reg_addr(n), saved_regs[n], $sformatf("register 0x%02h", reg_addr(n)));
        end
    endtask

    task automatic reset_values();
        check_value("model sbox[0x00]", {24'd0, sbox_byte(8'h00)}, 32'h18);
        check_value("model sbox[0x01]", {24'd0, sbox_byte(8'h01)}, 32'h23);
        check_value("model sbox[0x02]", {24'd0, sbox_byte(8'h02)}, 32'hc6);
        read_check(`WP_STATUS_ADDR, 32'h0, "status");
        for (int i = 0; i < 16; i++) begin
            read_check(word_addr(`WP_RESULT_BASE, i), 32'h0, $sformatf("result[%0d]", i));
            read_check(word_addr(`WP_KEY_BASE, i), 32'h0, $sformatf("key[%0d]", i));
        end
    endtask

    // Start write ends at edge 0; a read issued after edge n samples after edge n+2
    task automatic done_timing();
        load_key_block('0, '0);
        write_expect(`WP_CTRL_ADDR, 32'h1, 1'b0);
        repeat (8) @(posedge clk);
        read_check(`WP_STATUS_ADDR, 32'h1, "status after 10 cycles");
        write_expect(`WP_CTRL_ADDR, 32'h1, 1'b0);
        repeat (9) @(posedge clk);
        read_check(`WP_STATUS_ADDR, 32'h2, "status after 11 cycles");
        check_result(w_encrypt('0, '0));
    endtask

    task automatic random_encryptions();
        logic [511:0] k;
        logic [511:0] b;
        for (int n = 0; n < 20; n++) begin
            k = random_state();
            b = random_state();
            load_key_block(k, b);
            write_expect(`WP_CTRL_ADDR, 32'h1, 1'b0);
            wait_done();
            check_result(w_encrypt(k, b));
        end
    endtask

    task automatic register_readback();
        logic [511:0] k;
        logic [511:0] b;
        k = random_state();
        b = random_state();
        load_key_block(k, b);
        for (int i = 0; i < 16; i++) begin
            read_check(word_addr(`WP_KEY_BASE, i), k[511 - 32 * i -: 32], $sformatf("key[%0d]", i));
            read_check(word_addr(`WP_BLOCK_BASE, i), b[511 - 32 * i -: 32],
                       $sformatf("block[%0d]", i));
        end
        read_check(`WP_CTRL_ADDR, 32'h0, "control");
    endtask

    task automatic busy_protection();
        logic [511:0] k;
        logic [511:0] b;
        k = random_state();
        b = random_state();
        load_key_block(k, b);
        write_expect(`WP_CTRL_ADDR, 32'h1, 1'b0);
        write_expect(`WP_KEY_BASE, ~k[511 -: 32], 1'b1);
        write_expect(`WP_BLOCK_BASE, ~b[511 -: 32], 1'b1);
        write_expect(`WP_CTRL_ADDR, 32'h1, 1'b0); // Lands while busy and must be ignored
        // The first start was 9 edges back, so a restart would keep done low here
        read_check(`WP_STATUS_ADDR, 32'h2, "status after ignored start");
        check_result(w_encrypt(k, b));
        read_check(`WP_KEY_BASE, k[511 -: 32], "key[0]");
        read_check(`WP_BLOCK_BASE, b[511 -: 32], "block[0]");
        write_expect(`WP_CTRL_ADDR, 32'h1, 1'b0);
        read_check(`WP_STATUS_ADDR, 32'h1, "status after restart");
        wait_done();
    endtask

    task automatic bad_access();
        logic [31:0] d;
        logic        err;
        capture_regs();
        write_expect(8'h90, 32'hffff_ffff, 1'b1);
        check_regs_unchanged();
        write_expect(`WP_STATUS_ADDR, 32'hffff_ffff, 1'b1);
        check_regs_unchanged();
        write_expect(word_addr(`WP_RESULT_BASE, 1), 32'hffff_ffff, 1'b1);
        check_regs_unchanged();
        apb_read(8'ha0, d, err);
        check_value("pslverr on read of 0xa0", {31'd0, err}, 32'd1);
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $fatal(1);
    end

    initial begin
        clk     = 1'b0;
        rst     <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        void'($urandom(32'h4d6a3fdb));
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        reset_values();
        done_timing();
        random_encryptions();
        register_readback();
        busy_protection();
        bad_access();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== hw/whirlpool_top.sv ====
`include "whirlpool_settings.svh"

module whirlpool_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`WP_APB_AW-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);
    import whirlpool_pkg::*;

    wp_state_t key;
    wp_state_t block;
    wp_state_t result;
    logic      start;
    logic      busy;
    logic      done;

    whirlpool_apb_regs u_apb_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .key     (key),
        .block   (block),
        .start   (start),
        .result  (result),
        .busy    (busy),
        .done    (done)
    );

    whirlpool_wcipher u_wcipher (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .key    (key),
        .block  (block),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

endmodule

// ==== hw/whirlpool_apb_regs.sv ====
`include "whirlpool_settings.svh"

module whirlpool_apb_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`WP_APB_AW-1:0]     paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output whirlpool_pkg::wp_state_t  key,
    output whirlpool_pkg::wp_state_t  block,
    output logic                      start,
    input  whirlpool_pkg::wp_state_t  result,
    input  logic                      busy,
    input  logic                      done
);
    import whirlpool_pkg::*;

    logic        access;
    logic        wr;
    logic        rd;
    logic        aligned;
    logic [`WP_APB_AW-1:0] region; // Address with the word offset cleared
    logic [3:0]  word_idx;         // Word inside a 64-byte region
    logic        hit_key;
    logic        hit_block;
    logic        hit_ctrl;
    logic        hit_status;
    logic        hit_result;
    logic        mapped;
    logic        core_busy;
    logic        wr_ok;

    assign pready = 1'b1; // Every transfer completes in its access cycle

    assign access   = psel & penable;
    assign wr       = access & pwrite;
    assign rd       = access & ~pwrite;
    assign aligned  = paddr[1:0] == 2'b00;
    assign region   = {paddr[`WP_APB_AW-1:6], 6'd0};
    assign word_idx = paddr[5:2];

    assign hit_key    = aligned && region == `WP_KEY_BASE;
    assign hit_block  = aligned && region == `WP_BLOCK_BASE;
    assign hit_ctrl   = paddr == `WP_CTRL_ADDR;
    assign hit_status = paddr == `WP_STATUS_ADDR;
    assign hit_result = aligned && region == `WP_RESULT_BASE;
    assign mapped     = hit_key | hit_block | hit_ctrl | hit_status | hit_result;

    // A pending start pulse counts as busy so the inputs stay stable for the core
    assign core_busy = busy | start;

    assign pslverr = access & (~mapped
                             | (pwrite & (hit_status | hit_result))
                             | (pwrite & (hit_key | hit_block) & core_busy));

    assign wr_ok = wr & ~core_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            key   <= '0;
            block <= '0;
            start <= 1'b0;
        end else begin
            start <= wr_ok & hit_ctrl & pwdata[0]; // One-cycle pulse
            if (wr_ok && hit_key) begin
                key.flat[511 - 32 * word_idx -: 32] <= pwdata;
            end
            if (wr_ok && hit_block) begin
                block.flat[511 - 32 * word_idx -: 32] <= pwdata;
            end
        end
    end

    // Word i carries bytes 4i to 4i+3 with byte 4i on top
    always_comb begin
        prdata = '0;
        if (rd) begin
            if (hit_key) begin
                prdata = key.flat[511 - 32 * word_idx -: 32];
            end else if (hit_block) begin
                prdata = block.flat[511 - 32 * word_idx -: 32];
            end else if (hit_status) begin
                prdata = {30'd0, done, busy};
            end else if (hit_result) begin
                prdata = result.flat[511 - 32 * word_idx -: 32];
            end
        end
    end

endmodule

// ==== hw/whirlpool_wcipher.sv ====
`include "whirlpool_settings.svh"

module whirlpool_wcipher (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  whirlpool_pkg::wp_state_t  key,
    input  whirlpool_pkg::wp_state_t  block,
    output whirlpool_pkg::wp_state_t  result,
    output logic                      busy,
    output logic                      done
);
    import whirlpool_pkg::*;

    localparam int RND_W = $clog2(`WP_ROUNDS + 1);

    wp_state_t  key_q;       // Round key of the current round
    wp_state_t  state_q;
    wp_state_t  key_next;
    wp_state_t  state_next;
    wp_state_t  rc;          // Round constant for round rnd
    logic [4:0] rc_base;     // First S-box index of the constant in steps of eight
    wp_byte_t   rc_bytes [8];
    logic [RND_W-1:0] rnd;   // Round about to be applied, 1 to WP_ROUNDS

    // Row 0 of the constant takes eight consecutive S-box entries
    assign rc_base = {1'b0, rnd - 4'd1};

    for (genvar j = 0; j < 8; j++) begin : g_rc
        whirlpool_sbox u_rc_sbox (
            .in  ({rc_base, 3'(j)}),
            .out (rc_bytes[j])
        );
    end

    always_comb begin
        rc.flat = '0; // Rows 1 to 7 of the constant stay zero
        for (int j = 0; j < 8; j++) begin
            rc.mat[0][j] = rc_bytes[j];
        end
    end

    // Key schedule runs the same round function keyed by the constant
    whirlpool_round u_key_round (
        .state_in  (key_q),
        .round_key (rc),
        .state_out (key_next)
    );

    // Data path uses the round key produced in the same cycle
    whirlpool_round u_data_round (
        .state_in  (state_q),
        .round_key (key_next),
        .state_out (state_next)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            key_q   <= '0;
            state_q <= '0;
            rnd     <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else if (start) begin
            key_q.flat   <= key.flat;
            state_q.flat <= block.flat ^ key.flat; // Whitening with the cipher key
            rnd          <= RND_W'(1);
            busy         <= 1'b1;
            done         <= 1'b0;
        end else if (busy) begin
            key_q   <= key_next;
            state_q <= state_next;
            if (rnd == RND_W'(`WP_ROUNDS)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                rnd <= rnd + RND_W'(1);
            end
        end
    end

    assign result = state_q; // Valid while done is high

endmodule

// ==== hw/whirlpool_round.sv ====
module whirlpool_round (
    input  whirlpool_pkg::wp_state_t state_in,
    input  whirlpool_pkg::wp_state_t round_key,
    output whirlpool_pkg::wp_state_t state_out
);
    import whirlpool_pkg::*;

    // First row of the circulant theta matrix
    localparam logic [3:0] THETA_C [8] = '{
        4'h1, 4'h1, 4'h4, 4'h1, 4'h8, 4'h5, 4'h2, 4'h9
    };

    wp_byte_t  pi_out [8][8]; // Bytes after gamma and pi
    wp_state_t mixed;         // State after theta

    // Multiply by x modulo x^8+x^4+x^3+x^2+1
    function automatic wp_byte_t xtime(input wp_byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1d : 8'h00);
    endfunction

    // The theta coefficients never exceed 9, so four shift steps suffice
    function automatic wp_byte_t gf_mul(input wp_byte_t a, input logic [3:0] c);
        wp_byte_t acc;
        wp_byte_t p;
        acc = '0;
        p   = a;
        for (int b = 0; b < 4; b++) begin
            if (c[b]) begin
                acc = acc ^ p;
            end
            p = xtime(p);
        end
        return acc;
    endfunction

    // Each S-box output lands where pi rotates column j down by j rows
    for (genvar i = 0; i < 8; i++) begin : g_row
        for (genvar j = 0; j < 8; j++) begin : g_col
            whirlpool_sbox u_sbox (
                .in  (state_in.mat[i][j]),
                .out (pi_out[(i + j) % 8][j])
            );
        end
    end

    // Theta multiplies each row by cir(1,1,4,1,8,5,2,9)
    always_comb begin
        wp_byte_t acc;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 8; k++) begin
                acc = '0;
                for (int j = 0; j < 8; j++) begin
                    acc = acc ^ gf_mul(pi_out[i][j], THETA_C[(k - j + 8) % 8]);
                end
                mixed.mat[i][k] = acc;
            end
        end
    end

    assign state_out.flat = mixed.flat ^ round_key.flat; // Sigma

endmodule

// ==== hw/whirlpool_sbox.sv ====
module whirlpool_sbox (
    input  whirlpool_pkg::wp_byte_t in,
    output whirlpool_pkg::wp_byte_t out
);

    // E mini-box
    localparam logic [3:0] E_BOX [16] = '{
        4'h1, 4'hb, 4'h9, 4'hc, 4'hd, 4'h6, 4'hf, 4'h3,
        4'he, 4'h8, 4'h7, 4'h4, 4'ha, 4'h2, 4'h5, 4'h0
    };

    // Inverse of the E mini-box
    localparam logic [3:0] EI_BOX [16] = '{
        4'hf, 4'h0, 4'hd, 4'h7, 4'hb, 4'he, 4'h5, 4'ha,
        4'h9, 4'h2, 4'hc, 4'h1, 4'h3, 4'h4, 4'h8, 4'h6
    };

    // Randomly chosen R mini-box
    localparam logic [3:0] R_BOX [16] = '{
        4'h7, 4'hc, 4'hb, 4'hd, 4'he, 4'h4, 4'h9, 4'hf,
        4'h6, 4'h3, 4'h8, 4'ha, 4'h2, 4'h5, 4'h1, 4'h0
    };

    logic [3:0] e_hi;  // E of the upper nibble
    logic [3:0] ei_lo; // E-inverse of the lower nibble
    logic [3:0] r_mix; // R box output that feeds back into both halves

    assign e_hi  = E_BOX[in[7:4]];
    assign ei_lo = EI_BOX[in[3:0]];
    assign r_mix = R_BOX[e_hi ^ ei_lo];

    // Final pass restores the E / E-inverse pairing on the two halves
    assign out = {E_BOX[e_hi ^ r_mix], EI_BOX[ei_lo ^ r_mix]};

endmodule

// ==== hw/whirlpool_pkg.sv ====
package whirlpool_pkg;

    // One byte of the cipher state
    typedef logic [7:0] wp_byte_t;

    // One state row; column 0 sits in the most significant byte
    typedef wp_byte_t [0:7] wp_row_t;

    // The 512-bit state seen either as one word or as an 8x8 byte matrix.
    // Byte 8*row+col lands at bits 8*(8*row+col) .. +7 counted from the MSB,
    // so both members share the same layout and need no wiring between them.
    typedef union packed {
        logic [511:0]     flat; // Register and port view
        wp_row_t [0:7]    mat;  // Row 0 in the most significant 64 bits
    } wp_state_t;

endpackage

// ==== hw/whirlpool_settings.svh ====
`ifndef WHIRLPOOL_SETTINGS_SVH
`define WHIRLPOOL_SETTINGS_SVH

// Number of rounds of the W cipher
`define WP_ROUNDS 10

// APB byte address width
`define WP_APB_AW 8

// Register map offsets in bytes on the APB
`define WP_KEY_BASE    8'h00
`define WP_BLOCK_BASE  8'h40
`define WP_CTRL_ADDR   8'h80
`define WP_STATUS_ADDR 8'h84
`define WP_RESULT_BASE 8'hc0

`endif
